// ==== hdl/core_pkg.sv ====
package core_pkg;

    localparam int data_w      = 32;
    localparam int reg_addr_w  = 5;
    localparam int sram_addr_w = 8;                  // word index
    localparam int sram_depth  = 1 << sram_addr_w;   // 256 words

    // operation handed over by decode
    typedef enum logic [3:0] {
        op_alu,     // result is the summed value
        op_ld_b,
        op_ld_bu,
        op_ld_h,
        op_ld_hu,
        op_ld_w,
        op_st_b,
        op_st_h,
        op_st_w
    } mem_op_t;

    localparam logic [5:0] ecode_ale = 6'h09;        // address alignment error

endpackage

// ==== hdl/data_sram.sv ====
`timescale 1ns/100ps

module data_sram (
    input  logic                              clk,
    input  logic                              en,
    input  logic [3:0]                        we,
    input  logic [core_pkg::sram_addr_w-1:0]  addr,
    input  logic [core_pkg::data_w-1:0]       wdata,
    output logic [core_pkg::data_w-1:0]       rdata
);

    logic [core_pkg::data_w-1:0] mem [core_pkg::sram_depth];

    // byte-masked write, registered read
    always_ff @(posedge clk) begin
        if (en) begin
            if (|we) begin
                for (int i = 0; i < 4; i++) begin
                    if (we[i]) begin
                        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem[addr];   // held until next read
            end
        end
    end

    a_addr_known: assert property (@(posedge clk) en |-> !$isunknown(addr))
        else $error("data_sram: unknown address on access");

endmodule

// ==== hdl/ex_stage.sv ====
`timescale 1ns/100ps

module ex_stage (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              in_valid,
    output logic                              in_allowin,
    input  core_pkg::mem_op_t                 in_op,
    input  logic [core_pkg::reg_addr_w-1:0]   in_rd,
    input  logic                              in_rf_we,
    input  logic [core_pkg::data_w-1:0]       in_pc,
    input  logic [core_pkg::data_w-1:0]       in_base,
    input  logic [core_pkg::data_w-1:0]       in_offset,
    input  logic [core_pkg::data_w-1:0]       in_store_data,
    input  logic                              mem_allowin,
    input  logic                              mem_excep,
    input  logic                              wb_excep,
    input  logic                              flush,
    output logic                              out_valid,
    output core_pkg::mem_op_t                 out_op,
    output logic [core_pkg::reg_addr_w-1:0]   out_rd,
    output logic                              out_rf_we,
    output logic [core_pkg::data_w-1:0]       out_pc,
    output logic [core_pkg::data_w-1:0]       out_alu_value,
    output logic [1:0]                        out_addr_lo,
    output logic                              out_ale,
    output logic [core_pkg::data_w-1:0]       out_bad_vaddr,
    output logic                              sram_en,
    output logic [3:0]                        sram_we,
    output logic [core_pkg::sram_addr_w-1:0]  sram_addr,
    output logic [core_pkg::data_w-1:0]       sram_wdata
);

    logic                            ex_valid;
    core_pkg::mem_op_t               ex_op;
    logic [core_pkg::reg_addr_w-1:0] ex_rd;
    logic                            ex_rf_we;
    logic [core_pkg::data_w-1:0]     ex_pc;
    logic [core_pkg::data_w-1:0]     ex_base;
    logic [core_pkg::data_w-1:0]     ex_offset;
    logic [core_pkg::data_w-1:0]     ex_store_data;
    logic [core_pkg::data_w-1:0]     addr;
    logic                            is_half;
    logic                            is_word;
    logic                            is_store;
    logic                            ale;
    logic [3:0]                      st_strb;

    assign in_allowin = !ex_valid || mem_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;   // younger than the faulting entry
        end else if (in_allowin) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            ex_op         <= in_op;
            ex_rd         <= in_rd;
            ex_rf_we      <= in_rf_we;
            ex_pc         <= in_pc;
            ex_base       <= in_base;
            ex_offset     <= in_offset;
            ex_store_data <= in_store_data;
        end
    end

    assign addr     = ex_base + ex_offset;
    assign is_half  = ex_op inside {core_pkg::op_ld_h, core_pkg::op_ld_hu, core_pkg::op_st_h};
    assign is_word  = ex_op inside {core_pkg::op_ld_w, core_pkg::op_st_w};
    assign is_store = ex_op inside {core_pkg::op_st_b, core_pkg::op_st_h, core_pkg::op_st_w};
    assign ale      = (is_half && addr[0]) || (is_word && addr[1:0] != 2'b00);

    // lane placement for stores
    always_comb begin
        case (ex_op)
            core_pkg::op_st_b: begin
                st_strb    = 4'b0001 << addr[1:0];
                sram_wdata = {4{ex_store_data[7:0]}};
            end
            core_pkg::op_st_h: begin
                st_strb    = addr[1] ? 4'b1100 : 4'b0011;
                sram_wdata = {2{ex_store_data[15:0]}};
            end
            core_pkg::op_st_w: begin
                st_strb    = 4'b1111;
                sram_wdata = ex_store_data;
            end
            default: begin
                st_strb    = 4'b0000;
                sram_wdata = ex_store_data;
            end
        endcase
    end

    // stores also wait for older exceptions to clear
    assign sram_en = ex_valid && ex_op != core_pkg::op_alu && !ale && mem_allowin && !flush
                  && !(is_store && (mem_excep || wb_excep));
    assign sram_we   = sram_en ? st_strb : 4'b0000;
    assign sram_addr = addr[core_pkg::sram_addr_w+1:2];

    assign out_valid     = ex_valid;
    assign out_op        = ex_op;
    assign out_rd        = ex_rd;
    assign out_rf_we     = ex_rf_we;
    assign out_pc        = ex_pc;
    assign out_alu_value = addr;
    assign out_addr_lo   = addr[1:0];
    assign out_ale       = ale;
    assign out_bad_vaddr = addr;

    a_flush_from_excep: assert property (@(posedge clk) disable iff (!resetn)
        flush |-> wb_excep)
        else $error("ex_stage: flush without a faulting entry in WB");

endmodule

// ==== hdl/mem_stage.sv ====
`timescale 1ns/100ps

module mem_stage (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             in_valid,
    output logic                             in_allowin,
    input  core_pkg::mem_op_t                in_op,
    input  logic [core_pkg::reg_addr_w-1:0]  in_rd,
    input  logic                             in_rf_we,
    input  logic [core_pkg::data_w-1:0]      in_pc,
    input  logic [core_pkg::data_w-1:0]      in_alu_value,
    input  logic [1:0]                       in_addr_lo,
    input  logic                             in_ale,
    input  logic [core_pkg::data_w-1:0]      in_bad_vaddr,
    input  logic [core_pkg::data_w-1:0]      sram_rdata,
    input  logic                             wb_allowin,
    input  logic                             flush,
    output logic                             out_valid,
    output logic                             out_rf_we,
    output logic [core_pkg::reg_addr_w-1:0]  out_rd,
    output logic [core_pkg::data_w-1:0]      out_rf_wdata,
    output logic [core_pkg::data_w-1:0]      out_pc,
    output logic                             out_ale,
    output logic [core_pkg::data_w-1:0]      out_bad_vaddr,
    output logic                             mem_excep
);

    logic                            mem_valid;
    core_pkg::mem_op_t               mem_op;
    logic [core_pkg::reg_addr_w-1:0] mem_rd;
    logic                            mem_rf_we;
    logic [core_pkg::data_w-1:0]     mem_pc;
    logic [core_pkg::data_w-1:0]     mem_alu_value;
    logic [1:0]                      mem_addr_lo;
    logic                            mem_ale;
    logic [core_pkg::data_w-1:0]     mem_bad_vaddr;
    logic [15:0]                     half_data;
    logic [7:0]                      byte_data;
    logic                            is_store;

    assign in_allowin = !mem_valid || wb_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (flush) begin
            mem_valid <= 1'b0;
        end else if (in_allowin) begin
            mem_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            mem_op        <= in_op;
            mem_rd        <= in_rd;
            mem_rf_we     <= in_rf_we;
            mem_pc        <= in_pc;
            mem_alu_value <= in_alu_value;
            mem_addr_lo   <= in_addr_lo;
            mem_ale       <= in_ale;
            mem_bad_vaddr <= in_bad_vaddr;
        end
    end

    // lane select by low address bits
    assign half_data = mem_addr_lo[1] ? sram_rdata[31:16] : sram_rdata[15:0];

    always_comb begin
        case (mem_addr_lo)
            2'd0:    byte_data = sram_rdata[7:0];
            2'd1:    byte_data = sram_rdata[15:8];
            2'd2:    byte_data = sram_rdata[23:16];
            default: byte_data = sram_rdata[31:24];
        endcase
    end

    // extension, and alu value for everything that is not a load
    always_comb begin
        case (mem_op)
            core_pkg::op_ld_b:  out_rf_wdata = {{24{byte_data[7]}}, byte_data};
            core_pkg::op_ld_bu: out_rf_wdata = {24'b0, byte_data};
            core_pkg::op_ld_h:  out_rf_wdata = {{16{half_data[15]}}, half_data};
            core_pkg::op_ld_hu: out_rf_wdata = {16'b0, half_data};
            core_pkg::op_ld_w:  out_rf_wdata = sram_rdata;
            default:            out_rf_wdata = mem_alu_value;
        endcase
    end

    assign is_store = mem_op inside {core_pkg::op_st_b, core_pkg::op_st_h, core_pkg::op_st_w};

    assign out_valid     = mem_valid;
    assign out_rf_we     = mem_rf_we && !mem_ale && !is_store;
    assign out_rd        = mem_rd;
    assign out_pc        = mem_pc;
    assign out_ale       = mem_ale;
    assign out_bad_vaddr = mem_bad_vaddr;
    assign mem_excep     = mem_valid && mem_ale;   // level, back to EX

    // only halfword and word accesses can be misaligned
    a_ale_on_sized_access: assert property (@(posedge clk) disable iff (!resetn)
        (in_valid && in_ale) |-> in_op inside {core_pkg::op_ld_h, core_pkg::op_ld_hu,
            core_pkg::op_ld_w, core_pkg::op_st_h, core_pkg::op_st_w})
        else $error("mem_stage: alignment fault on a byte or alu operation");

endmodule

// ==== hdl/wb_stage.sv ====
`timescale 1ns/100ps

module wb_stage (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             in_valid,
    output logic                             in_allowin,
    input  logic                             in_rf_we,
    input  logic [core_pkg::reg_addr_w-1:0]  in_rd,
    input  logic [core_pkg::data_w-1:0]      in_rf_wdata,
    input  logic [core_pkg::data_w-1:0]      in_pc,
    input  logic                             in_ale,
    input  logic [core_pkg::data_w-1:0]      in_bad_vaddr,
    input  logic                             commit_ready,
    output logic                             commit_valid,
    output logic                             commit_rf_we,
    output logic [core_pkg::reg_addr_w-1:0]  commit_rd,
    output logic [core_pkg::data_w-1:0]      commit_wdata,
    output logic [core_pkg::data_w-1:0]      commit_pc,
    output logic                             excep_valid,
    output logic [5:0]                       excep_code,
    output logic [core_pkg::data_w-1:0]      excep_badv,
    output logic                             wb_excep,
    output logic                             flush
);

    logic                            wb_valid;
    logic                            wb_rf_we;
    logic [core_pkg::reg_addr_w-1:0] wb_rd;
    logic [core_pkg::data_w-1:0]     wb_wdata;
    logic [core_pkg::data_w-1:0]     wb_pc;
    logic                            wb_ale;
    logic [core_pkg::data_w-1:0]     wb_bad_vaddr;

    assign in_allowin = !wb_valid || commit_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (in_allowin) begin
            wb_valid <= in_valid && !flush;   // entry behind a fault is dropped
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            wb_rf_we     <= in_rf_we;
            wb_rd        <= in_rd;
            wb_wdata     <= in_rf_wdata;
            wb_pc        <= in_pc;
            wb_ale       <= in_ale;
            wb_bad_vaddr <= in_bad_vaddr;
        end
    end

    assign wb_excep = wb_valid && wb_ale;
    assign flush    = wb_excep && commit_ready;   // pulses as the fault leaves

    assign commit_valid = wb_valid && !wb_ale;
    assign commit_rf_we = wb_rf_we && wb_rd != '0;   // r0 is never written
    assign commit_rd    = wb_rd;
    assign commit_wdata = wb_wdata;
    assign commit_pc    = wb_pc;
    assign excep_valid  = wb_excep;
    assign excep_code   = core_pkg::ecode_ale;
    assign excep_badv   = wb_bad_vaddr;

endmodule

// ==== hdl/lsu_pipe_top.sv ====
`timescale 1ns/100ps

module lsu_pipe_top (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             issue_valid,
    output logic                             issue_allowin,
    input  core_pkg::mem_op_t                issue_op,
    input  logic [core_pkg::reg_addr_w-1:0]  issue_rd,
    input  logic                             issue_rf_we,
    input  logic [core_pkg::data_w-1:0]      issue_pc,
    input  logic [core_pkg::data_w-1:0]      issue_base,
    input  logic [core_pkg::data_w-1:0]      issue_offset,
    input  logic [core_pkg::data_w-1:0]      issue_store_data,
    input  logic                             commit_ready,
    output logic                             commit_valid,
    output logic                             commit_rf_we,
    output logic [core_pkg::reg_addr_w-1:0]  commit_rd,
    output logic [core_pkg::data_w-1:0]      commit_wdata,
    output logic [core_pkg::data_w-1:0]      commit_pc,
    output logic                             excep_valid,
    output logic [5:0]                       excep_code,
    output logic [core_pkg::data_w-1:0]      excep_badv
);

    // ex to mem
    logic                            ex_valid;
    core_pkg::mem_op_t               ex_op;
    logic [core_pkg::reg_addr_w-1:0] ex_rd;
    logic                            ex_rf_we;
    logic [core_pkg::data_w-1:0]     ex_pc;
    logic [core_pkg::data_w-1:0]     ex_alu_value;
    logic [1:0]                      ex_addr_lo;
    logic                            ex_ale;
    logic [core_pkg::data_w-1:0]     ex_bad_vaddr;
    // mem to wb
    logic                            mem_valid;
    logic                            mem_rf_we;
    logic [core_pkg::reg_addr_w-1:0] mem_rd;
    logic [core_pkg::data_w-1:0]     mem_rf_wdata;
    logic [core_pkg::data_w-1:0]     mem_pc;
    logic                            mem_ale;
    logic [core_pkg::data_w-1:0]     mem_bad_vaddr;
    logic                            mem_allowin;
    logic                            wb_allowin;
    logic                            mem_excep;
    logic                            wb_excep;
    logic                            flush;
    logic                            sram_en;
    logic [3:0]                      sram_we;
    logic [core_pkg::sram_addr_w-1:0] sram_addr;
    logic [core_pkg::data_w-1:0]     sram_wdata;
    logic [core_pkg::data_w-1:0]     sram_rdata;

    ex_stage u_ex (
        .clk(clk), .resetn(resetn),
        .in_valid(issue_valid), .in_allowin(issue_allowin), .in_op(issue_op),
        .in_rd(issue_rd), .in_rf_we(issue_rf_we), .in_pc(issue_pc),
        .in_base(issue_base), .in_offset(issue_offset), .in_store_data(issue_store_data),
        .mem_allowin(mem_allowin), .mem_excep(mem_excep), .wb_excep(wb_excep), .flush(flush),
        .out_valid(ex_valid), .out_op(ex_op), .out_rd(ex_rd), .out_rf_we(ex_rf_we),
        .out_pc(ex_pc), .out_alu_value(ex_alu_value), .out_addr_lo(ex_addr_lo),
        .out_ale(ex_ale), .out_bad_vaddr(ex_bad_vaddr),
        .sram_en(sram_en), .sram_we(sram_we), .sram_addr(sram_addr), .sram_wdata(sram_wdata)
    );

    data_sram u_sram (
        .clk(clk), .en(sram_en), .we(sram_we), .addr(sram_addr),
        .wdata(sram_wdata), .rdata(sram_rdata)
    );

    mem_stage u_mem (
        .clk(clk), .resetn(resetn),
        .in_valid(ex_valid), .in_allowin(mem_allowin), .in_op(ex_op), .in_rd(ex_rd),
        .in_rf_we(ex_rf_we), .in_pc(ex_pc), .in_alu_value(ex_alu_value),
        .in_addr_lo(ex_addr_lo), .in_ale(ex_ale), .in_bad_vaddr(ex_bad_vaddr),
        .sram_rdata(sram_rdata), .wb_allowin(wb_allowin), .flush(flush),
        .out_valid(mem_valid), .out_rf_we(mem_rf_we), .out_rd(mem_rd),
        .out_rf_wdata(mem_rf_wdata), .out_pc(mem_pc), .out_ale(mem_ale),
        .out_bad_vaddr(mem_bad_vaddr), .mem_excep(mem_excep)
    );

    wb_stage u_wb (
        .clk(clk), .resetn(resetn),
        .in_valid(mem_valid), .in_allowin(wb_allowin), .in_rf_we(mem_rf_we),
        .in_rd(mem_rd), .in_rf_wdata(mem_rf_wdata), .in_pc(mem_pc),
        .in_ale(mem_ale), .in_bad_vaddr(mem_bad_vaddr), .commit_ready(commit_ready),
        .commit_valid(commit_valid), .commit_rf_we(commit_rf_we), .commit_rd(commit_rd),
        .commit_wdata(commit_wdata), .commit_pc(commit_pc), .excep_valid(excep_valid),
        .excep_code(excep_code), .excep_badv(excep_badv), .wb_excep(wb_excep), .flush(flush)
    );

endmodule

// ==== dv/lsu_pipe_tb.sv ====
`timescale 1ns/100ps

module lsu_pipe_tb;

    typedef struct packed {
        core_pkg::mem_op_t op;
        logic [4:0]        rd;
        logic [31:0]       pc;
        logic [31:0]       addr;
        logic [31:0]       data;
        logic              timed;   // latency checked
        logic [31:0]       cycle;
    } exp_t;

    logic              clk;
    logic              resetn;
    logic              issue_valid;
    logic              issue_allowin;
    core_pkg::mem_op_t issue_op;
    logic [4:0]        issue_rd;
    logic              issue_rf_we;
    logic [31:0]       issue_pc;
    logic [31:0]       issue_base;
    logic [31:0]       issue_offset;
    logic [31:0]       issue_store_data;
    logic              commit_ready;
    logic              commit_valid;
    logic              commit_rf_we;
    logic [4:0]        commit_rd;
    logic [31:0]       commit_wdata;
    logic [31:0]       commit_pc;
    logic              excep_valid;
    logic [5:0]        excep_code;
    logic [31:0]       excep_badv;

    // stimulus table
    core_pkg::mem_op_t t_op [128];
    logic [4:0]        t_rd [128];
    logic [31:0]       t_base [128];
    logic [31:0]       t_off [128];
    logic [31:0]       t_data [128];
    int                t_test [128];
    bit                t_drain [128];
    int                n_rows = 0;
    bit                table_done = 0;
    string             test_name [6];
    bit                test_rand_ready [6];

    logic [31:0] ref_mem [256];   // reference copy of the SRAM
    exp_t        exp_q [$];
    int          chk_count [6];
    int          err_count [6];
    int          cur_test = 0;
    int          rand_ready = 0;
    int          cyc = 0;
    integer      seed = 6607;
    logic [31:0] rnd;

    lsu_pipe_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ready pattern, random only where the test asks for it
    initial begin
        bit use_rand;
        forever begin
            @(posedge clk);
            use_rand = (rand_ready != 0);   // taken at the edge, ahead of the drives
            #1;
            rnd = $random(seed);
            commit_ready = use_rand ? rnd[0] : 1'b1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_count[cur_test]++;
        assert (got === exp) else begin
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
            err_count[cur_test]++;
        end
    endtask

    task automatic report(input string what);
        $display("%s at t=%0t", what, $time);
        err_count[cur_test]++;
    endtask

    function automatic bit is_store(input core_pkg::mem_op_t op);
        return op inside {core_pkg::op_st_b, core_pkg::op_st_h, core_pkg::op_st_w};
    endfunction

    // halfword at odd address, word off a 4-byte boundary
    function automatic bit is_ale(input core_pkg::mem_op_t op, input logic [31:0] addr);
        if (op inside {core_pkg::op_ld_h, core_pkg::op_ld_hu, core_pkg::op_st_h})
            return addr[0];
        if (op inside {core_pkg::op_ld_w, core_pkg::op_st_w})
            return addr[1:0] != 2'b00;
        return 1'b0;
    endfunction

    function automatic logic [31:0] expected_wdata(input exp_t e);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = ref_mem[e.addr[9:2]];
        b = w[8*e.addr[1:0] +: 8];
        h = e.addr[1] ? w[31:16] : w[15:0];
        case (e.op)
            core_pkg::op_ld_b:  return {{24{b[7]}}, b};
            core_pkg::op_ld_bu: return {24'b0, b};
            core_pkg::op_ld_h:  return {{16{h[15]}}, h};
            core_pkg::op_ld_hu: return {16'b0, h};
            core_pkg::op_ld_w:  return w;
            default:            return e.addr;
        endcase
    endfunction

    task automatic model_store(input exp_t e);
        case (e.op)
            core_pkg::op_st_b: ref_mem[e.addr[9:2]][8*e.addr[1:0] +: 8] = e.data[7:0];
            core_pkg::op_st_h: begin
                if (e.addr[1]) ref_mem[e.addr[9:2]][31:16] = e.data[15:0];
                else ref_mem[e.addr[9:2]][15:0] = e.data[15:0];
            end
            core_pkg::op_st_w: ref_mem[e.addr[9:2]] = e.data;
            default: ;
        endcase
    endtask

    // outputs are stable at the falling edge; transfers happen on the next rise
    always @(negedge clk) begin
        exp_t e;
        bit   flushed;
        flushed = 1'b0;
        if (resetn && excep_valid && commit_ready) begin
            assert (exp_q.size() != 0)
                else report("exception reported with no operation outstanding");
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (is_ale(e.op, e.addr))
                    else report("exception on an aligned operation");
                check_value("commit_valid", 32'(commit_valid), 32'd0);
                check_value("excep_code", 32'(excep_code), 32'(core_pkg::ecode_ale));
                check_value("excep_badv", excep_badv, e.addr);
                check_value("commit_pc", commit_pc, e.pc);
            end
            exp_q.delete();   // younger entries are squashed
            flushed = 1'b1;
        end else if (resetn && commit_valid && commit_ready) begin
            assert (exp_q.size() != 0)
                else report("commit with no operation outstanding");
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (!is_ale(e.op, e.addr))
                    else report("misaligned operation committed");
                check_value("commit_pc", commit_pc, e.pc);
                check_value("commit_rf_we", 32'(commit_rf_we),
                            32'(e.rd != 5'd0 && !is_store(e.op)));
                if (e.rd != 5'd0 && !is_store(e.op)) begin
                    check_value("commit_rd", 32'(commit_rd), 32'(e.rd));
                    check_value("commit_wdata", commit_wdata, expected_wdata(e));
                end
                if (e.timed) check_value("commit_latency", cyc - e.cycle, 32'd3);
                model_store(e);
            end
        end
        if (resetn && issue_valid && issue_allowin && !flushed) begin
            e.op    = issue_op;
            e.rd    = issue_rd;
            e.pc    = issue_pc;
            e.addr  = issue_base + issue_offset;
            e.data  = issue_store_data;
            e.timed = (cur_test == 1);
            e.cycle = cyc;
            exp_q.push_back(e);
        end
    end

    task automatic add_row(input int test, input core_pkg::mem_op_t op, input logic [4:0] rd,
                           input logic [31:0] base, input logic [31:0] off,
                           input logic [31:0] data, input bit drain);
        t_test[n_rows]  = test;
        t_op[n_rows]    = op;
        t_rd[n_rows]    = rd;
        t_base[n_rows]  = base;
        t_off[n_rows]   = off;
        t_data[n_rows]  = data;
        t_drain[n_rows] = drain;
        n_rows++;
    endtask

    task automatic build_table();
        core_pkg::mem_op_t ops [9];
        logic [31:0] r;
        ops = '{core_pkg::op_alu, core_pkg::op_alu, core_pkg::op_st_w, core_pkg::op_st_h,
                core_pkg::op_st_b, core_pkg::op_ld_w, core_pkg::op_ld_h, core_pkg::op_ld_bu,
                core_pkg::op_ld_b};
        for (int i = 0; i < 8; i++)
            add_row(1, core_pkg::op_alu, 5'(i * 3), $random(seed), $random(seed), 0, 0);
        add_row(2, core_pkg::op_st_w, 0, 32'h40, 32'h0, 32'h8bad_f00d, 0);
        add_row(2, core_pkg::op_st_w, 0, 32'h44, 32'h0, 32'h1234_5678, 0);
        add_row(2, core_pkg::op_st_h, 0, 32'h40, 32'h6, 32'hffff_f1e2, 0);
        add_row(2, core_pkg::op_st_b, 0, 32'h40, 32'h5, 32'h0000_007c, 0);
        for (int a = 0; a < 8; a++) begin
            add_row(2, core_pkg::op_ld_b, 5'd1, 32'h40, 32'(a), 0, 0);
            add_row(2, core_pkg::op_ld_bu, 5'd2, 32'h40, 32'(a), 0, 0);
        end
        for (int a = 0; a < 8; a += 2) begin
            add_row(2, core_pkg::op_ld_h, 5'd3, 32'h40, 32'(a), 0, 0);
            add_row(2, core_pkg::op_ld_hu, 5'd4, 32'h40, 32'(a), 0, 0);
        end
        add_row(2, core_pkg::op_ld_w, 5'd5, 32'h40, 32'h0, 0, 0);
        add_row(2, core_pkg::op_ld_w, 5'd6, 32'h40, 32'h4, 0, 0);
        for (int w = 0; w < 8; w++)
            add_row(3, core_pkg::op_st_w, 0, 32'h100, 32'(w * 4), $random(seed), 0);
        for (int i = 0; i < 30; i++) begin
            r = $random(seed);
            add_row(3, ops[r[3:0] % 9], 5'(r[8:4]), 32'h100 + 32'({r[14:12], 2'b00}),
                    {30'b0, r[16:15]} & ((r[3:0] % 9 inside {3, 6}) ? 32'h2 :
                    (r[3:0] % 9 inside {4, 7, 8}) ? 32'h3 : 32'h0), $random(seed), 0);
        end
        add_row(4, core_pkg::op_ld_h, 5'd7, 32'h40, 32'h1, 0, 1);
        add_row(4, core_pkg::op_ld_w, 5'd8, 32'h40, 32'h2, 0, 1);
        add_row(4, core_pkg::op_st_w, 0, 32'h43, 32'h0, 32'hdead_beef, 1);
        add_row(5, core_pkg::op_st_w, 0, 32'h80, 32'h0, 32'h1122_3344, 0);
        add_row(5, core_pkg::op_st_w, 0, 32'h84, 32'h0, 32'h5566_7788, 1);
        add_row(5, core_pkg::op_ld_hu, 5'd9, 32'h80, 32'h1, 0, 0);
        add_row(5, core_pkg::op_st_w, 0, 32'h80, 32'h0, 32'hbad0_bad0, 0);
        add_row(5, core_pkg::op_st_b, 0, 32'h84, 32'h0, 32'h0000_00ee, 0);
        add_row(5, core_pkg::op_ld_w, 5'd10, 32'h84, 32'h0, 0, 1);
        add_row(5, core_pkg::op_ld_w, 5'd11, 32'h80, 32'h0, 0, 0);
        add_row(5, core_pkg::op_ld_w, 5'd12, 32'h84, 32'h0, 0, 1);
        table_done = 1;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);   // room for a stray commit to show up
        #1;
    endtask

    task automatic print_test(input int t);
        $display("test %0d %s: %0d checks, %0d errors", t, test_name[t],
                 chk_count[t], err_count[t]);
    endtask

    initial begin
        test_name = '{"reset", "alu", "store_load", "backpressure", "ale", "squash"};
        test_rand_ready = '{0, 0, 0, 1, 0, 0};
        resetn = 1'b0;
        issue_valid = 1'b0;
        issue_op = core_pkg::op_alu;
        issue_rd = '0;
        issue_rf_we = 1'b0;
        issue_pc = '0;
        issue_base = '0;
        issue_offset = '0;
        issue_store_data = '0;
        commit_ready = 1'b1;
        build_table();
        @(posedge clk);
        repeat (7) begin
            @(negedge clk);
            check_value("commit_valid", 32'(commit_valid), 32'd0);
            check_value("excep_valid", 32'(excep_valid), 32'd0);
        end
        @(posedge clk);
        #1 resetn = 1'b1;
        @(negedge clk);
        check_value("commit_valid", 32'(commit_valid), 32'd0);
        check_value("excep_valid", 32'(excep_valid), 32'd0);
        check_value("issue_allowin", 32'(issue_allowin), 32'd1);
        print_test(0);
        @(posedge clk);
        #1;
        for (int i = 0; i < n_rows; i++) begin
            cur_test = t_test[i];
            rand_ready = test_rand_ready[cur_test];
            issue_valid = 1'b1;
            issue_op = t_op[i];
            issue_rd = t_rd[i];
            issue_rf_we = !is_store(t_op[i]);
            issue_pc = 32'h1000 + 32'(i * 4);
            issue_base = t_base[i];
            issue_offset = t_off[i];
            issue_store_data = t_data[i];
            @(negedge clk);
            while (!issue_allowin) @(negedge clk);
            @(posedge clk);
            #1 issue_valid = 1'b0;
            if (t_drain[i] || i == n_rows - 1 || t_test[i + 1] != cur_test) drain();
            if (i == n_rows - 1 || t_test[i + 1] != cur_test) print_test(cur_test);
        end
        begin
            int errs;
            int chks;
            errs = 0;
            chks = 0;
            for (int t = 0; t < 6; t++) begin
                errs += err_count[t];
                chks += chk_count[t];
            end
            $display("tests 6, checks %0d, errors %0d", chks, errs);
            if (errs == 0) $display("** PASS **");
            else $display("** FAIL **");
        end
        $finish;
    end

    // watchdog, 20 cycles per table row
    initial begin
        wait (table_done);
        #(n_rows * 20 * 4 + 200);
        $display("timeout: the pipeline stopped committing");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== build.f ====
hdl/core_pkg.sv
hdl/data_sram.sv
hdl/ex_stage.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/lsu_pipe_top.sv
dv/lsu_pipe_tb.sv

// ==== Makefile ====
# Verilator flow for the load/store pipeline testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module lsu_pipe_tb \
		-Mdir $(OBJ_DIR) -o lsu_pipe_sim
	./$(OBJ_DIR)/lsu_pipe_sim | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
